/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= mem_stage_tb
FILELIST  ?= sim.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/dcache_pkg.sv
verilog/line_ram.sv
verilog/access_stage.sv
verilog/dcache.sv
verilog/load_align.sv
verilog/mem_stage.sv
tests/main_memory_model.sv
tests/mem_stage_tb.sv

/* tests/main_memory_model.sv */
// Behavioural main memory

`timescale 1ns/1ps

module main_memory_model (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  mem_pkg::addr_t      mem_addr,
    input  mem_pkg::mem_block_t mem_wdata,
    output logic                mem_rvalid,
    output mem_pkg::mem_block_t mem_rdata
);

    import mem_pkg::*;

    logic [7:0]  mem_bytes [65536];
    integer      seed;
    int unsigned wait_left; // Cycles until the refill returns
    addr_t       pend_addr;

    // Initial contents depend on every address bit
    function automatic logic [7:0] fill_byte(input addr_t a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5a;
    endfunction

    function automatic mem_block_t read_block(input addr_t base);
        mem_block_t blk;
        for (int i = 0; i < 8; i++) begin
            blk.bytes[i] = mem_bytes[base + 16'(i)];
        end
        return blk;
    endfunction

    initial begin
        seed = 32'he707;
        for (int a = 0; a < 65536; a++) begin
            mem_bytes[a] = fill_byte(16'(a));
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            mem_rvalid <= 1'b0;
            wait_left  <= 0;
        end else begin
            mem_rvalid <= 1'b0;
            if (mem_wr) begin
                for (int i = 0; i < 8; i++) begin
                    mem_bytes[mem_addr + 16'(i)] = mem_wdata.bytes[i];
                end
            end
            if (mem_rd) begin
                pend_addr <= mem_addr;
                wait_left <= 2 + $unsigned($random(seed)) % 8; // 2 to 9 cycles
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
                if (wait_left == 1) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= read_block(pend_addr);
                end
            end
        end
    end

endmodule

/* tests/mem_stage_tb.sv */
// Memory stage testbench

`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_stage_tb;

    import mem_pkg::*;

    localparam int TIMEOUT = 100;

    logic       clock, reset, req_valid, req_store, req_unsigned;
    addr_t      req_addr;
    mem_size_e  req_size;
    data_t      req_data;
    logic       busy, ld_valid, mem_rd, mem_wr, mem_rvalid;
    data_t      ld_data;
    addr_t      mem_addr;
    mem_block_t mem_wdata, mem_rdata;

    logic [7:0]                  shadow [65536]; // Expected memory contents
    logic                        tag_valid [`DCACHE_LINES];
    logic [`DCACHE_TAG_BITS-1:0] tag_value [`DCACHE_LINES];
    data_t                       load_queue [$];
    addr_t                       wr_addr_queue [$];
    mem_block_t                  wr_block_queue [$];
    addr_t                       fetch_addr;
    int                          rd_count, errors, checks;
    integer                      seed;

    mem_stage i_mem_stage (.*);
    main_memory_model i_memory (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic predict_hit(input addr_t a);
        return tag_valid[a[7:3]] && (tag_value[a[7:3]] == a[15:8]);
    endfunction

    // Extended load value from the little-endian shadow memory
    function automatic data_t expected_load(input addr_t a, input mem_size_e s, input logic u);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[a + 16'd1], shadow[a]};
        case (s)
            SIZE_BYTE: return u ? {24'b0, b} : {{24{b[7]}}, b};
            SIZE_HALF: return u ? {16'b0, h} : {{16{h[15]}}, h};
            default:   return {shadow[a + 16'd3], shadow[a + 16'd2], h};
        endcase
    endfunction

    function automatic mem_block_t shadow_block(input addr_t base);
        mem_block_t blk;
        for (int i = 0; i < 8; i++) begin
            blk.bytes[i] = shadow[base + 16'(i)];
        end
        return blk;
    endfunction

    // Update the models, queue the expected results, drive one request
    task automatic issue_req(input addr_t a, input logic st, input mem_size_e s,
                             input logic u, input data_t d);
        addr_t base;
        int    n;
        base = {a[15:3], 3'b000};
        n    = (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
        if (!predict_hit(a)) fetch_addr = base;
        tag_valid[a[7:3]] = 1'b1; // Allocate on load and store misses
        tag_value[a[7:3]] = a[15:8];
        if (st) begin
            for (int i = 0; i < n; i++) shadow[a + 16'(i)] = d[8*i +: 8];
            wr_addr_queue.push_back(base);
            wr_block_queue.push_back(shadow_block(base));
        end else begin
            load_queue.push_back(expected_load(a, s, u));
        end
        @(posedge clock);
        req_valid    <= 1'b1;
        req_addr     <= a;
        req_store    <= st;
        req_size     <= s;
        req_unsigned <= u;
        req_data     <= d;
    endtask

    task automatic do_access(input string name, input addr_t a, input logic st,
                             input mem_size_e s, input logic u, input data_t d);
        logic       hit;
        logic       seen;
        logic [1:0] first_cycle; // Busy and fetch strobe in the cycle after the request
        int         rd_start;
        int         n;
        hit         = predict_hit(a);
        rd_start    = rd_count;
        seen        = 1'b0;
        first_cycle = 2'b00;
        n           = 0;
        issue_req(a, st, s, u, d);
        @(posedge clock);
        req_valid <= 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clock);
            n++;
            if (n == 1) begin
                first_cycle = {busy, mem_rd};
            end
            seen = st ? mem_wr : ld_valid;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: %s at address %h never completed", name, a);
        end else begin
            if (hit) begin
                check({name, " latency"}, 2, n);
            end
            check({name, " busy at result"}, 0, busy);
        end
        check({name, " busy and fetch start"}, hit ? 2'b00 : 2'b11, first_cycle);
        check({name, " fetch count"}, hit ? 0 : 1, rd_count - rd_start);
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (busy) begin
            errors++;
            $display("Timeout: busy stayed high after %s", name);
        end
    endtask

    // Loads on consecutive edges to lines held in the cache
    task automatic burst_loads(input addr_t base, input int count);
        int rd_start;
        int n;
        rd_start = rd_count;
        for (int i = 0; i < count; i++) begin
            issue_req(base + 16'(i), 1'b0, SIZE_BYTE, i[0], '0);
        end
        @(posedge clock);
        req_valid <= 1'b0;
        n = 0;
        while (load_queue.size() != 0 && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (load_queue.size() != 0) begin
            errors++;
            $display("Timeout: burst of hit loads did not return every result");
        end
        check("burst fetch count", 0, rd_count - rd_start);
    endtask

    // Compares every result the DUT produces
    always @(negedge clock) begin
        if (!reset) begin
            if (ld_valid) begin
                if (load_queue.size() == 0) begin
                    errors++;
                    $display("A load result arrived with no load outstanding");
                end else begin
                    check("load data", load_queue.pop_front(), ld_data);
                end
            end
            if (mem_wr) begin
                if (wr_block_queue.size() == 0) begin
                    errors++;
                    $display("A memory write appeared with no store outstanding");
                end else begin
                    check("write address", wr_addr_queue.pop_front(), mem_addr);
                    check("write block", wr_block_queue.pop_front(), mem_wdata);
                end
            end
            if (mem_rd) begin
                rd_count++;
                check("fetch address", fetch_addr, mem_addr);
            end
        end
    end

    initial begin
        addr_t     a;
        mem_size_e s;
        seed         = 32'he707;
        errors       = 0;
        checks       = 0;
        rd_count     = 0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_store    = 1'b0;
        req_size     = SIZE_BYTE;
        req_unsigned = 1'b0;
        req_data     = '0;
        for (int i = 0; i < 65536; i++) shadow[i] = 8'(i) ^ {i[12:8], i[15:13]} ^ 8'h5a;
        for (int i = 0; i < `DCACHE_LINES; i++) tag_valid[i] = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clock);
            check("idle outputs", 4'b0000, {busy, ld_valid, mem_rd, mem_wr});
        end
        do_access("first load", 16'h0124, 1'b0, SIZE_WORD, 1'b0, '0);
        for (int k = 0; k < 6; k++) begin // Misses of every size and sign
            do_access("load miss", 16'h2080 + 16'(k * 8 + 4), 1'b0, mem_size_e'(k / 2), k[0], '0);
        end
        do_access("load hit", 16'h0122, 1'b0, SIZE_HALF, 1'b0, '0);
        do_access("load hit", 16'h0127, 1'b0, SIZE_BYTE, 1'b0, '0);
        burst_loads(16'h2088, 8);
        do_access("store hit", 16'h0122, 1'b1, SIZE_HALF, 1'b0, 32'h0000_beef);
        do_access("load back", 16'h0122, 1'b0, SIZE_HALF, 1'b0, '0);
        do_access("store miss", 16'h3304, 1'b1, SIZE_WORD, 1'b0, 32'h89ab_cdef);
        do_access("load back", 16'h3307, 1'b0, SIZE_BYTE, 1'b0, '0);
        for (int k = 0; k < 6; k++) begin // Tags 04 and 05 share one index
            do_access("conflict", k[0] ? 16'h0540 : 16'h0440, 1'b0, SIZE_WORD, 1'b0, '0);
        end
        for (int k = 0; k < 400; k++) begin
            s    = mem_size_e'($unsigned($random(seed)) % 3);
            a    = {6'b010000, 2'($random(seed)), 5'($unsigned($random(seed)) % 8),
                    3'($random(seed))};
            a    = (s == SIZE_HALF) ? {a[15:1], 1'b0} : (s == SIZE_WORD) ? {a[15:2], 2'b00} : a;
            do_access("random", a, 1'($random(seed)), s, 1'($random(seed)), $random(seed));
        end
        repeat (4) @(posedge clock);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/access_stage.sv */
// Request and miss control

`timescale 1ns/1ps
`include "dcache_consts.svh"

module access_stage (
    input  logic                clock,
    input  logic                reset,

    // Processor request
    input  logic                req_valid,
    input  mem_pkg::addr_t      req_addr,
    input  logic                req_store,
    input  mem_pkg::mem_size_e  req_size,
    input  logic                req_unsigned,
    input  mem_pkg::data_t      req_data,

    // Lookup result from the cache
    input  logic                hit,
    input  mem_pkg::mem_block_t store_block,

    // Memory refill
    input  logic                mem_rvalid,
    input  mem_pkg::mem_block_t mem_rdata,

    output logic                busy,

    // Held request, seen by the cache and the align stage
    output logic                look_valid,
    output mem_pkg::addr_t      look_addr,
    output logic                look_store,
    output mem_pkg::mem_size_e  look_size,
    output logic                look_unsigned,
    output mem_pkg::data_t      look_data,

    output logic                fill_wr,
    output mem_pkg::mem_block_t fill_data,

    // Memory commands
    output logic                mem_rd,
    output logic                mem_wr,
    output mem_pkg::addr_t      mem_addr,
    output mem_pkg::mem_block_t mem_wdata,

    output logic                res_valid // Load result to the align stage
);

    import mem_pkg::*;
    import dcache_pkg::*;

    miss_state_e state;
    miss_state_e next_state;
    logic        miss;
    logic        done;
    addr_t       block_addr;
    addr_t       wr_addr; // Block address of the pending write-through

    assign miss = look_valid && !hit;
    assign done = look_valid && hit; // Hit, or the replay after a refill

    assign block_addr = {look_addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    // Stall from the first cycle of a miss until the replay retires
    assign busy = miss || (state != MISS_IDLE);

    // A fetch waits one cycle if a write-through owns the memory port
    assign mem_rd    = (state == MISS_IDLE) && miss && !mem_wr;
    assign mem_addr  = mem_wr ? wr_addr : block_addr;

    assign fill_wr   = (state == MISS_FETCH) && mem_rvalid;
    assign fill_data = mem_rdata;

    assign res_valid = done && !look_store;

    always_comb begin
        next_state = state;
        case (state)
            MISS_IDLE: begin
                if (miss && !mem_wr) begin
                    next_state = MISS_FETCH;
                end
            end
            MISS_FETCH: begin
                if (mem_rvalid) begin
                    next_state = MISS_FILL;
                end
            end
            default: begin
                next_state = MISS_IDLE; // Replay takes one cycle
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= MISS_IDLE;
            look_valid <= 1'b0;
            mem_wr     <= 1'b0;
        end else begin
            state  <= next_state;
            mem_wr <= done && look_store; // Write-through of every store
            if (!busy) begin
                look_valid <= req_valid;
            end else if (state == MISS_FILL) begin
                look_valid <= 1'b0; // Replayed access retires
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!busy && req_valid) begin
            look_addr     <= req_addr;
            look_store    <= req_store;
            look_size     <= req_size;
            look_unsigned <= req_unsigned;
            look_data     <= req_data;
        end
        if (done && look_store) begin
            wr_addr   <= block_addr;
            mem_wdata <= store_block; // Whole merged block
        end
    end

endmodule

/* verilog/dcache.sv */
// Direct-mapped data cache lookup

`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache (
    input  logic                          clock,
    input  logic                          reset,

    input  logic                          look_valid,
    input  mem_pkg::addr_t                look_addr,
    input  logic                          look_store,
    input  mem_pkg::mem_size_e            look_size,
    input  mem_pkg::data_t                look_data,

    input  logic                          fill_wr,
    input  mem_pkg::mem_block_t           fill_data,

    output logic                          hit,
    output mem_pkg::mem_block_t           line_data,   // Block for the load path
    output mem_pkg::mem_block_t           store_block, // Block with store data merged

    // Line RAM
    output logic [`DCACHE_INDEX_BITS-1:0] ram_raddr,
    output logic                          ram_we,
    output logic [`DCACHE_INDEX_BITS-1:0] ram_waddr,
    output mem_pkg::mem_block_t           ram_wdata,
    input  mem_pkg::mem_block_t           ram_rdata
);

    import mem_pkg::*;
    import dcache_pkg::*;

    logic [`DCACHE_TAG_BITS-1:0]     look_tag;
    logic [`DCACHE_INDEX_BITS-1:0]   look_index;
    logic [`OFFSET_BITS-1:0]         look_offset;
    dcache_tag_t [`DCACHE_LINES-1:0] tags;
    mem_block_t                      sel_block;
    mem_block_t                      merged;

    assign {look_tag, look_index, look_offset} = look_addr;

    assign hit = tags[look_index].valid && (tags[look_index].tag == look_tag);

    // Refill data bypasses the RAM in the cycle it arrives
    always_comb begin
        sel_block = fill_wr ? fill_data : ram_rdata;
        merged    = sel_block;
        case (look_size)
            SIZE_BYTE: merged.bytes[look_offset]                   = look_data[7:0];
            SIZE_HALF: merged.halves[look_offset[`OFFSET_BITS-1:1]] = look_data[15:0];
            default:   merged.words[look_offset[`OFFSET_BITS-1]]   = look_data;
        endcase
    end

    assign line_data   = sel_block;
    assign store_block = merged;

    assign ram_raddr = look_index;
    assign ram_waddr = look_index;
    assign ram_we    = fill_wr || (look_valid && look_store && hit);
    assign ram_wdata = look_store ? merged : fill_data; // Store miss merges into the refill

    always_ff @(posedge clock) begin
        if (reset) begin
            tags <= '0; // All lines invalid
        end else if (fill_wr) begin
            tags[look_index] <= '{valid: 1'b1, tag: look_tag};
        end
    end

endmodule

/* verilog/dcache_consts.svh */
// Data cache geometry

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Cache shape
`define DCACHE_LINES      32
`define DCACHE_INDEX_BITS 5
`define DCACHE_TAG_BITS   8

// Address layout, tag | index | offset
`define ADDR_BITS   16
`define BLOCK_BYTES 8
`define OFFSET_BITS 3

`endif

/* verilog/dcache_pkg.sv */
// Data cache types

`include "dcache_consts.svh"

package dcache_pkg;

    // Tag entry per line
    typedef struct packed {
        logic                        valid;
        logic [`DCACHE_TAG_BITS-1:0] tag;
    } dcache_tag_t;

    // Miss handling
    typedef enum logic [1:0] {
        MISS_IDLE  = 2'h0, // No miss outstanding
        MISS_FETCH = 2'h1, // Block requested, waiting for memory
        MISS_FILL  = 2'h2  // Line refilled, access replayed
    } miss_state_e;

endpackage

/* verilog/line_ram.sv */
// Block storage RAM

`timescale 1ns/1ps

module line_ram #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic                     we,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Asynchronous read, a same-cycle write shows up only after the edge
    assign rdata = mem[raddr];

    // Contents are left alone on reset, the tag array marks them invalid
    always_ff @(posedge clock) begin
        if (we && !reset) begin // No writes while in reset
            mem[waddr] <= wdata;
        end
    end

endmodule

/* verilog/load_align.sv */
// Load data alignment

`timescale 1ns/1ps
`include "dcache_consts.svh"

module load_align (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    res_valid,
    input  mem_pkg::mem_block_t     line_data,
    input  logic [`OFFSET_BITS-1:0] res_offset,
    input  mem_pkg::mem_size_e      res_size,
    input  logic                    res_unsigned,
    output logic                    ld_valid,
    output mem_pkg::data_t          ld_data
);

    import mem_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    data_t       sel_word;
    data_t       ext_data;

    // Pick the addressed element of the block, then extend to a word
    always_comb begin
        sel_byte = line_data.bytes[res_offset];
        sel_half = line_data.halves[res_offset[`OFFSET_BITS-1:1]];
        sel_word = line_data.words[res_offset[`OFFSET_BITS-1]];
        case (res_size)
            SIZE_BYTE: begin
                ext_data = res_unsigned ? {24'b0, sel_byte} : {{24{sel_byte[7]}}, sel_byte};
            end
            SIZE_HALF: begin
                ext_data = res_unsigned ? {16'b0, sel_half} : {{16{sel_half[15]}}, sel_half};
            end
            default: begin
                ext_data = sel_word; // Full word, nothing to extend
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= res_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (res_valid) begin
            ld_data <= ext_data; // Held until the next load
        end
    end

endmodule

/* verilog/mem_pkg.sv */
// Memory side types

`include "dcache_consts.svh"

package mem_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t; // Byte address
    typedef logic [31:0]           data_t; // Processor word

    // One cache block, viewed at the width of the access
    typedef union packed {
        logic [`BLOCK_BYTES-1:0][7:0]    bytes;
        logic [`BLOCK_BYTES/2-1:0][15:0] halves;
        logic [`BLOCK_BYTES/4-1:0][31:0] words;
    } mem_block_t;

    // Access width of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'h0,
        SIZE_HALF = 2'h1,
        SIZE_WORD = 2'h2
    } mem_size_e;

endpackage

/* verilog/mem_stage.sv */
// Memory stage top

`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_stage (
    input  logic                clock,
    input  logic                reset,

    // Processor side
    input  logic                req_valid,
    input  mem_pkg::addr_t      req_addr,
    input  logic                req_store,
    input  mem_pkg::mem_size_e  req_size,
    input  logic                req_unsigned,
    input  mem_pkg::data_t      req_data,
    output logic                busy,
    output logic                ld_valid,
    output mem_pkg::data_t      ld_data,

    // Memory side
    output logic                mem_rd,
    output logic                mem_wr,
    output mem_pkg::addr_t      mem_addr,
    output mem_pkg::mem_block_t mem_wdata,
    input  logic                mem_rvalid,
    input  mem_pkg::mem_block_t mem_rdata
);

    import mem_pkg::*;

    // Held request
    logic      look_valid;
    addr_t     look_addr;
    logic      look_store;
    mem_size_e look_size;
    logic      look_unsigned;
    data_t     look_data;

    logic       fill_wr;
    mem_block_t fill_data;
    logic       hit;
    mem_block_t store_block;
    mem_block_t line_data;
    logic       res_valid;

    // Line RAM ports
    logic [`DCACHE_INDEX_BITS-1:0] ram_raddr;
    logic [`DCACHE_INDEX_BITS-1:0] ram_waddr;
    logic                          ram_we;
    mem_block_t                    ram_wdata;
    mem_block_t                    ram_rdata;

    access_stage i_access_stage (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_store    (req_store),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_data     (req_data),
        .hit          (hit),
        .store_block  (store_block),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .busy         (busy),
        .look_valid   (look_valid),
        .look_addr    (look_addr),
        .look_store   (look_store),
        .look_size    (look_size),
        .look_unsigned(look_unsigned),
        .look_data    (look_data),
        .fill_wr      (fill_wr),
        .fill_data    (fill_data),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .res_valid    (res_valid)
    );

    dcache i_dcache (
        .clock      (clock),
        .reset      (reset),
        .look_valid (look_valid),
        .look_addr  (look_addr),
        .look_store (look_store),
        .look_size  (look_size),
        .look_data  (look_data),
        .fill_wr    (fill_wr),
        .fill_data  (fill_data),
        .hit        (hit),
        .line_data  (line_data),
        .store_block(store_block),
        .ram_raddr  (ram_raddr),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    line_ram #(
        .WIDTH($bits(mem_block_t)),
        .DEPTH(`DCACHE_LINES)
    ) i_line_ram (
        .clock(clock),
        .reset(reset),
        .raddr(ram_raddr),
        .waddr(ram_waddr),
        .we   (ram_we),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    // Offset, size and sign come straight from the held request
    load_align i_load_align (
        .clock       (clock),
        .reset       (reset),
        .res_valid   (res_valid),
        .line_data   (line_data),
        .res_offset  (look_addr[`OFFSET_BITS-1:0]),
        .res_size    (look_size),
        .res_unsigned(look_unsigned),
        .ld_valid    (ld_valid),
        .ld_data     (ld_data)
    );

endmodule
